// File: hdl/arm_pkg.sv
`default_nettype none

package arm_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 4;

    localparam logic [REG_ADDR_W-1:0] PC_REG  = 4'd15;
    localparam logic [REG_ADDR_W-1:0] LR_REG  = 4'd14;
    localparam logic [DATA_W-1:0]     DONE_PC = 32'hFFFF_FFFC;  // Last word address

    // Values match the opcode field of the instruction
    typedef enum logic [3:0] {
        ALU_AND = 4'b0000,
        ALU_EOR = 4'b0001,
        ALU_SUB = 4'b0010,
        ALU_RSB = 4'b0011,
        ALU_ADD = 4'b0100,
        ALU_CMP = 4'b1010,
        ALU_ORR = 4'b1100,
        ALU_MOV = 4'b1101,
        ALU_MVN = 4'b1111
    } alu_op_e;

    typedef enum logic [3:0] {
        COND_EQ, COND_NE, COND_CS, COND_CC, COND_MI, COND_PL, COND_VS, COND_VC,
        COND_HI, COND_LS, COND_GE, COND_LT, COND_GT, COND_LE, COND_AL
    } cond_e;

    typedef enum logic [1:0] {FWD_NONE, FWD_EXMEM, FWD_MEMWB} fwd_sel_e;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wb_sel_e;

    typedef struct packed {
        logic [3:0]            cond;
        logic [1:0]            cls;       // 00 here
        logic                  imm;
        logic [3:0]            opcode;
        logic                  s;
        logic [REG_ADDR_W-1:0] rn;
        logic [REG_ADDR_W-1:0] rd;
        logic [11:0]           operand2;  // Rotate and imm8, or Rm
    } dp_fmt_t;

    typedef struct packed {
        logic [3:0]            cond;
        logic [1:0]            cls;       // 01 here
        logic                  reg_off;
        logic                  p;
        logic                  u;
        logic                  b;
        logic                  w;
        logic                  l;
        logic [REG_ADDR_W-1:0] rn;
        logic [REG_ADDR_W-1:0] rd;
        logic [11:0]           offset12;
    } ls_fmt_t;

    typedef struct packed {
        logic [3:0]  cond;
        logic [1:0]  cls;                 // 10 here
        logic        one;                 // Set for B and BL, clear for block transfer
        logic        link;
        logic [23:0] offset24;
    } br_fmt_t;

    typedef union packed {
        dp_fmt_t dp_fmt;
        ls_fmt_t ls_fmt;
        br_fmt_t br_fmt;
    } instr_u;

    typedef struct packed {
        cond_e   cond;
        alu_op_e alu_op;
        logic    use_imm;
        logic    set_flags;
        logic    is_branch;
        logic    is_link;
        logic    mem_read;
        logic    mem_write;
        logic    pre_index;
        wb_sel_e wb_sel;
        logic    wr_en;
        logic    writes_result;           // Rd is the destination
        logic    use_rn;
        logic    use_rm;
        logic    use_rd;
    } ctrl_t;

    typedef struct packed {
        logic                  valid;
        ctrl_t                 ctrl;
        logic [DATA_W-1:0]     pc_plus8;
        logic [REG_ADDR_W-1:0] rn_addr;
        logic [REG_ADDR_W-1:0] rm_addr;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic [DATA_W-1:0]     rn_data;
        logic [DATA_W-1:0]     rm_data;
        logic [DATA_W-1:0]     rd_data;
        logic [DATA_W-1:0]     imm32;
    } idex_t;

    typedef struct packed {
        logic                  wr_en;
        logic [REG_ADDR_W-1:0] wr_addr;
        wb_sel_e               wb_sel;
        logic                  mem_read;
        logic                  mem_write;
        logic [DATA_W-1:0]     alu_result;
        logic [DATA_W-1:0]     mem_addr;
        logic [DATA_W-1:0]     store_data;
        logic [DATA_W-1:0]     pc_plus4;
    } exmem_t;

    typedef struct packed {
        logic                  wr_en;
        logic [REG_ADDR_W-1:0] wr_addr;
        wb_sel_e               wb_sel;
        logic [DATA_W-1:0]     alu_result;
        logic [DATA_W-1:0]     pc_plus4;
    } memwb_t;

endpackage

`default_nettype wire

// File: hdl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       stall_i,
    input  wire logic                       flush_i,
    input  wire logic                       branch_taken_i,
    input  wire logic [arm_pkg::DATA_W-1:0] branch_target_i,
    input  wire logic [arm_pkg::DATA_W-1:0] i_mem_data_i,
    output logic [arm_pkg::DATA_W-1:0]      i_mem_addr_o,
    output arm_pkg::instr_u                 instr_o,
    output logic [arm_pkg::DATA_W-1:0]      pc_plus4_o,
    output logic                            valid_o
);

    logic [arm_pkg::DATA_W-1:0] pc_q;
    logic [arm_pkg::DATA_W-1:0] pc_plus4;
    logic [arm_pkg::DATA_W-1:0] hold_q;
    logic                       held_q;

    assign pc_plus4     = pc_q + 32'd4;
    assign i_mem_addr_o = pc_q;
    assign instr_o      = held_q ? hold_q : i_mem_data_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= '0;
        end else if (branch_taken_i) begin
            pc_q <= branch_target_i;
        end else if (!stall_i) begin
            pc_q <= pc_plus4;
        end
    end

    // IF/ID register, the word itself comes straight from the memory
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_plus4_o <= '0;
            valid_o    <= 1'b0;
        end else if (flush_i) begin
            valid_o <= 1'b0;
        end else if (!stall_i) begin
            pc_plus4_o <= pc_plus4;
            valid_o    <= 1'b1;
        end
    end

    // While stalled the memory already returns the following word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_q <= 1'b0;
        end else if (flush_i || !stall_i) begin
            held_q <= 1'b0;
        end else begin
            held_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (stall_i && !held_q) begin
            hold_q <= i_mem_data_i;  // First stall cycle only
        end
    end

endmodule

`default_nettype wire

// File: hdl/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  wire arm_pkg::instr_u                  instr_i,
    input  wire logic                             valid_i,
    output arm_pkg::ctrl_t                        ctrl_o,
    output logic [arm_pkg::REG_ADDR_W-1:0]        rn_o,
    output logic [arm_pkg::REG_ADDR_W-1:0]        rm_o,
    output logic [arm_pkg::REG_ADDR_W-1:0]        rd_o,
    output logic [arm_pkg::DATA_W-1:0]            imm32_o
);

    arm_pkg::alu_op_e op;
    logic [63:0]      imm_dbl;
    logic             dp_ok;
    logic             ls_ok;
    logic             supported;

    // Register fields sit in the same bits for every kept format
    assign rn_o = instr_i.dp_fmt.rn;
    assign rd_o = instr_i.dp_fmt.rd;
    assign rm_o = instr_i.dp_fmt.operand2[3:0];
    assign op   = arm_pkg::alu_op_e'(instr_i.dp_fmt.opcode);

    // Rotate right by twice the 4-bit field
    assign imm_dbl = {2{24'd0, instr_i.dp_fmt.operand2[7:0]}}
                     >> {instr_i.dp_fmt.operand2[11:8], 1'b0};

    assign dp_ok = (instr_i.dp_fmt.imm || instr_i.dp_fmt.operand2[11:4] == 8'd0)
                   && (op inside {arm_pkg::ALU_AND, arm_pkg::ALU_EOR, arm_pkg::ALU_SUB,
                                  arm_pkg::ALU_RSB, arm_pkg::ALU_ADD, arm_pkg::ALU_CMP,
                                  arm_pkg::ALU_ORR, arm_pkg::ALU_MOV, arm_pkg::ALU_MVN})
                   && (op != arm_pkg::ALU_CMP || instr_i.dp_fmt.s);  // CMP without S is MRS

    // Word access, immediate offset, no base writeback
    assign ls_ok = !instr_i.ls_fmt.reg_off && !instr_i.ls_fmt.b && !instr_i.ls_fmt.w;

    always_comb begin
        ctrl_o    = '0;
        imm32_o   = '0;
        supported = 1'b0;
        case (instr_i.dp_fmt.cls)
            2'b00: begin
                imm32_o              = imm_dbl[31:0];
                ctrl_o.alu_op        = op;
                ctrl_o.use_imm       = instr_i.dp_fmt.imm;
                ctrl_o.set_flags     = instr_i.dp_fmt.s;
                ctrl_o.writes_result = (op != arm_pkg::ALU_CMP);
                ctrl_o.use_rn        = !(op inside {arm_pkg::ALU_MOV, arm_pkg::ALU_MVN});
                ctrl_o.use_rm        = !instr_i.dp_fmt.imm;
                supported            = dp_ok;
            end
            2'b01: begin
                imm32_o              = {20'd0, instr_i.ls_fmt.offset12};
                ctrl_o.alu_op        = instr_i.ls_fmt.u ? arm_pkg::ALU_ADD : arm_pkg::ALU_SUB;
                ctrl_o.use_imm       = 1'b1;
                ctrl_o.mem_read      = instr_i.ls_fmt.l;
                ctrl_o.mem_write     = !instr_i.ls_fmt.l;
                ctrl_o.pre_index     = instr_i.ls_fmt.p;
                ctrl_o.wb_sel        = arm_pkg::WB_MEM;
                ctrl_o.writes_result = instr_i.ls_fmt.l;
                ctrl_o.use_rn        = 1'b1;
                ctrl_o.use_rd        = !instr_i.ls_fmt.l;  // Store data
                supported            = ls_ok;
            end
            2'b10: begin
                imm32_o          = {{6{instr_i.br_fmt.offset24[23]}},
                                    instr_i.br_fmt.offset24, 2'b00};
                ctrl_o.is_branch = 1'b1;
                ctrl_o.is_link   = instr_i.br_fmt.link;
                ctrl_o.wb_sel    = arm_pkg::WB_LINK;
                supported        = instr_i.br_fmt.one;
            end
            default: ;
        endcase
        ctrl_o.cond  = arm_pkg::cond_e'(instr_i.dp_fmt.cond);
        ctrl_o.wr_en = ctrl_o.writes_result || ctrl_o.is_link;
        if (!valid_i || !supported || instr_i.dp_fmt.cond == 4'hF) begin
            ctrl_o = '0;  // Bubble
        end
    end

endmodule

`default_nettype wire

// File: hdl/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  wire logic                             clk,
    input  wire logic                             rst_n,
    input  wire logic [arm_pkg::REG_ADDR_W-1:0]   ra_i,
    input  wire logic [arm_pkg::REG_ADDR_W-1:0]   rb_i,
    input  wire logic [arm_pkg::REG_ADDR_W-1:0]   rc_i,
    input  wire logic [arm_pkg::DATA_W-1:0]       pc_plus8_i,
    input  wire logic                             we_i,
    input  wire logic [arm_pkg::REG_ADDR_W-1:0]   wa_i,
    input  wire logic [arm_pkg::DATA_W-1:0]       wd_i,
    output logic [arm_pkg::DATA_W-1:0]            ra_o,
    output logic [arm_pkg::DATA_W-1:0]            rb_o,
    output logic [arm_pkg::DATA_W-1:0]            rc_o
);

    logic [arm_pkg::DATA_W-1:0] regs_q [16];

    function automatic logic [arm_pkg::DATA_W-1:0] read_port(
        input logic [arm_pkg::REG_ADDR_W-1:0] addr
    );
        if (addr == arm_pkg::PC_REG) begin
            return pc_plus8_i;
        end
        if (we_i && wa_i == addr) begin
            return wd_i;  // Write-through from WB
        end
        return regs_q[addr];
    endfunction

    always_comb begin
        ra_o = read_port(ra_i);
        rb_o = read_port(rb_i);
        rc_o = read_port(rc_i);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i) begin
            regs_q[wa_i] <= wd_i;
        end
    end

endmodule

`default_nettype wire

// File: hdl/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  wire logic [arm_pkg::REG_ADDR_W-1:0] rn_i,
    input  wire logic [arm_pkg::REG_ADDR_W-1:0] rm_i,
    input  wire logic [arm_pkg::REG_ADDR_W-1:0] rd_i,
    input  wire logic                           use_rn_i,
    input  wire logic                           use_rm_i,
    input  wire logic                           use_rd_i,
    input  wire arm_pkg::idex_t                 idex_i,
    input  wire arm_pkg::exmem_t                exmem_i,
    input  wire arm_pkg::memwb_t                memwb_i,
    input  wire logic                           branch_taken_i,
    output logic                                stall_o,
    output logic                                flush_ifid_o,
    output logic                                flush_idex_o,
    output arm_pkg::fwd_sel_e                   fwd_a_o,
    output arm_pkg::fwd_sel_e                   fwd_b_o,
    output arm_pkg::fwd_sel_e                   fwd_d_o
);

    logic load_in_ex;

    function automatic logic load_hit(
        input logic [arm_pkg::REG_ADDR_W-1:0] addr,
        input logic                           use_src,
        input logic [arm_pkg::REG_ADDR_W-1:0] dest
    );
        return use_src && addr != arm_pkg::PC_REG && addr == dest;
    endfunction

    // Youngest producer wins, loads in EX/MEM are covered by the stall
    function automatic arm_pkg::fwd_sel_e src_sel(
        input logic [arm_pkg::REG_ADDR_W-1:0] addr,
        input logic                           use_src,
        input arm_pkg::exmem_t                em,
        input arm_pkg::memwb_t                mw
    );
        if (!use_src || addr == arm_pkg::PC_REG) begin
            return arm_pkg::FWD_NONE;
        end
        if (em.wr_en && !em.mem_read && em.wr_addr == addr) begin
            return arm_pkg::FWD_EXMEM;
        end
        if (mw.wr_en && mw.wr_addr == addr) begin
            return arm_pkg::FWD_MEMWB;
        end
        return arm_pkg::FWD_NONE;
    endfunction

    assign load_in_ex = idex_i.valid && idex_i.ctrl.mem_read && idex_i.ctrl.writes_result;

    assign stall_o = load_in_ex && (load_hit(rn_i, use_rn_i, idex_i.rd_addr)
                                 || load_hit(rm_i, use_rm_i, idex_i.rd_addr)
                                 || load_hit(rd_i, use_rd_i, idex_i.rd_addr));

    assign flush_ifid_o = branch_taken_i;
    assign flush_idex_o = branch_taken_i || stall_o;  // Stall leaves a bubble in EX

    assign fwd_a_o = src_sel(idex_i.rn_addr, idex_i.ctrl.use_rn, exmem_i, memwb_i);
    assign fwd_b_o = src_sel(idex_i.rm_addr, idex_i.ctrl.use_rm, exmem_i, memwb_i);
    assign fwd_d_o = src_sel(idex_i.rd_addr, idex_i.ctrl.use_rd, exmem_i, memwb_i);

endmodule

`default_nettype wire

// File: hdl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire arm_pkg::idex_t             idex_i,
    input  wire arm_pkg::fwd_sel_e          fwd_a_i,
    input  wire arm_pkg::fwd_sel_e          fwd_b_i,
    input  wire arm_pkg::fwd_sel_e          fwd_d_i,
    input  wire logic [arm_pkg::DATA_W-1:0] exmem_fwd_i,
    input  wire logic [arm_pkg::DATA_W-1:0] memwb_fwd_i,
    output arm_pkg::exmem_t                 exmem_o,
    output logic                            branch_taken_o,
    output logic [arm_pkg::DATA_W-1:0]      branch_target_o
);

    logic [3:0]                 nzcv_q;
    logic [3:0]                 nzcv_d;
    logic [arm_pkg::DATA_W-1:0] op_a;
    logic [arm_pkg::DATA_W-1:0] op_b;
    logic [arm_pkg::DATA_W-1:0] rm_val;
    logic [arm_pkg::DATA_W-1:0] st_val;
    logic [arm_pkg::DATA_W-1:0] result;
    logic [arm_pkg::DATA_W-1:0] add_x;
    logic [arm_pkg::DATA_W-1:0] add_y;
    logic                       add_cin;
    logic [arm_pkg::DATA_W:0]   sum;
    logic                       overflow;
    logic                       is_arith;
    logic                       cond_ok;

    function automatic logic [arm_pkg::DATA_W-1:0] fwd_mux(
        input arm_pkg::fwd_sel_e          sel,
        input logic [arm_pkg::DATA_W-1:0] reg_val
    );
        case (sel)
            arm_pkg::FWD_EXMEM: return exmem_fwd_i;
            arm_pkg::FWD_MEMWB: return memwb_fwd_i;
            default:            return reg_val;
        endcase
    endfunction

    function automatic logic cond_pass(input arm_pkg::cond_e cond, input logic [3:0] f);
        logic n, z, c, v;
        {n, z, c, v} = f;
        case (cond)
            arm_pkg::COND_EQ: return z;
            arm_pkg::COND_NE: return !z;
            arm_pkg::COND_CS: return c;
            arm_pkg::COND_CC: return !c;
            arm_pkg::COND_MI: return n;
            arm_pkg::COND_PL: return !n;
            arm_pkg::COND_VS: return v;
            arm_pkg::COND_VC: return !v;
            arm_pkg::COND_HI: return c && !z;
            arm_pkg::COND_LS: return !c || z;
            arm_pkg::COND_GE: return n == v;
            arm_pkg::COND_LT: return n != v;
            arm_pkg::COND_GT: return !z && (n == v);
            arm_pkg::COND_LE: return z || (n != v);
            default:          return 1'b1;
        endcase
    endfunction

    always_comb begin
        op_a   = fwd_mux(fwd_a_i, idex_i.rn_data);
        rm_val = fwd_mux(fwd_b_i, idex_i.rm_data);
        st_val = fwd_mux(fwd_d_i, idex_i.rd_data);
        op_b   = idex_i.ctrl.use_imm ? idex_i.imm32 : rm_val;
    end

    // One adder, subtraction as x + ~y + 1 so C is the inverted borrow
    always_comb begin
        add_x   = op_a;
        add_y   = op_b;
        add_cin = 1'b0;
        case (idex_i.ctrl.alu_op)
            arm_pkg::ALU_SUB, arm_pkg::ALU_CMP: begin
                add_y   = ~op_b;
                add_cin = 1'b1;
            end
            arm_pkg::ALU_RSB: begin
                add_x   = op_b;
                add_y   = ~op_a;
                add_cin = 1'b1;
            end
            default: ;
        endcase
    end

    assign sum      = {1'b0, add_x} + {1'b0, add_y} + 33'(add_cin);
    assign overflow = (add_x[31] == add_y[31]) && (sum[31] != add_x[31]);

    always_comb begin
        case (idex_i.ctrl.alu_op)
            arm_pkg::ALU_AND: result = op_a & op_b;
            arm_pkg::ALU_EOR: result = op_a ^ op_b;
            arm_pkg::ALU_ORR: result = op_a | op_b;
            arm_pkg::ALU_MOV: result = op_b;
            arm_pkg::ALU_MVN: result = ~op_b;
            default:          result = sum[31:0];
        endcase
    end

    // Logical ops leave C and V alone, there is no shifter carry
    assign is_arith = idex_i.ctrl.alu_op inside {arm_pkg::ALU_SUB, arm_pkg::ALU_RSB,
                                                 arm_pkg::ALU_ADD, arm_pkg::ALU_CMP};
    assign nzcv_d   = {result[31], result == '0,
                       is_arith ? sum[32] : nzcv_q[1],
                       is_arith ? overflow : nzcv_q[0]};

    // Flags land on the edge that ends EX, so the next instruction sees them
    assign cond_ok = idex_i.valid && cond_pass(idex_i.ctrl.cond, nzcv_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            nzcv_q <= 4'b0000;
        end else if (cond_ok && idex_i.ctrl.set_flags) begin
            nzcv_q <= nzcv_d;
        end
    end

    assign branch_taken_o  = cond_ok && idex_i.ctrl.is_branch;
    assign branch_target_o = idex_i.pc_plus8 + idex_i.imm32;

    always_comb begin
        exmem_o.wr_en      = cond_ok && idex_i.ctrl.wr_en;
        exmem_o.wr_addr    = idex_i.ctrl.is_link ? arm_pkg::LR_REG : idex_i.rd_addr;
        exmem_o.wb_sel     = idex_i.ctrl.wb_sel;
        exmem_o.mem_read   = cond_ok && idex_i.ctrl.mem_read;
        exmem_o.mem_write  = cond_ok && idex_i.ctrl.mem_write;
        exmem_o.alu_result = result;
        exmem_o.mem_addr   = idex_i.ctrl.pre_index ? result : op_a;  // Post-index uses Rn
        exmem_o.store_data = st_val;
        exmem_o.pc_plus4   = idex_i.pc_plus8 - 32'd4;
    end

endmodule

`default_nettype wire

// File: hdl/arm_core.sv
`timescale 1ns/1ps
`default_nettype none

module arm_core (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic [arm_pkg::DATA_W-1:0] i_mem_data_i,
    output logic [arm_pkg::DATA_W-1:0]      i_mem_addr_o,
    input  wire logic [arm_pkg::DATA_W-1:0] d_mem_data_i,
    output logic [arm_pkg::DATA_W-1:0]      d_mem_addr_o,
    output logic [arm_pkg::DATA_W-1:0]      d_mem_data_o,
    output logic                            d_mem_wen_o,
    output logic                            done_o
);

    logic                               stall;
    logic                               flush_ifid;
    logic                               flush_idex;
    logic                               branch_taken;
    logic [arm_pkg::DATA_W-1:0]         branch_target;
    arm_pkg::instr_u                    instr_id;
    logic [arm_pkg::DATA_W-1:0]         pc_plus4_id;
    logic [arm_pkg::DATA_W-1:0]         pc_plus8_id;
    logic                               valid_id;
    arm_pkg::ctrl_t                     ctrl_id;
    logic [arm_pkg::REG_ADDR_W-1:0]     rn_id;
    logic [arm_pkg::REG_ADDR_W-1:0]     rm_id;
    logic [arm_pkg::REG_ADDR_W-1:0]     rd_id;
    logic [arm_pkg::DATA_W-1:0]         imm32_id;
    logic [arm_pkg::DATA_W-1:0]         rn_data_id;
    logic [arm_pkg::DATA_W-1:0]         rm_data_id;
    logic [arm_pkg::DATA_W-1:0]         rd_data_id;
    arm_pkg::idex_t                     idex_q;
    arm_pkg::exmem_t                    exmem_d;
    arm_pkg::exmem_t                    exmem_q;
    arm_pkg::memwb_t                    memwb_q;
    arm_pkg::fwd_sel_e                  fwd_a;
    arm_pkg::fwd_sel_e                  fwd_b;
    arm_pkg::fwd_sel_e                  fwd_d;
    logic [arm_pkg::DATA_W-1:0]         exmem_fwd;
    logic [arm_pkg::DATA_W-1:0]         wb_data;

    assign pc_plus8_id = pc_plus4_id + 32'd4;
    assign done_o      = (i_mem_addr_o == arm_pkg::DONE_PC);

    fetch_stage fetch_stage_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .stall_i         (stall),
        .flush_i         (flush_ifid),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .i_mem_data_i    (i_mem_data_i),
        .i_mem_addr_o    (i_mem_addr_o),
        .instr_o         (instr_id),
        .pc_plus4_o      (pc_plus4_id),
        .valid_o         (valid_id)
    );

    decoder decoder_i (
        .instr_i (instr_id),
        .valid_i (valid_id),
        .ctrl_o  (ctrl_id),
        .rn_o    (rn_id),
        .rm_o    (rm_id),
        .rd_o    (rd_id),
        .imm32_o (imm32_id)
    );

    regfile regfile_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ra_i       (rn_id),
        .rb_i       (rm_id),
        .rc_i       (rd_id),
        .pc_plus8_i (pc_plus8_id),
        .we_i       (memwb_q.wr_en),
        .wa_i       (memwb_q.wr_addr),
        .wd_i       (wb_data),
        .ra_o       (rn_data_id),
        .rb_o       (rm_data_id),
        .rc_o       (rd_data_id)
    );

    hazard_unit hazard_unit_i (
        .rn_i           (rn_id),
        .rm_i           (rm_id),
        .rd_i           (rd_id),
        .use_rn_i       (ctrl_id.use_rn),
        .use_rm_i       (ctrl_id.use_rm),
        .use_rd_i       (ctrl_id.use_rd),
        .idex_i         (idex_q),
        .exmem_i        (exmem_q),
        .memwb_i        (memwb_q),
        .branch_taken_i (branch_taken),
        .stall_o        (stall),
        .flush_ifid_o   (flush_ifid),
        .flush_idex_o   (flush_idex),
        .fwd_a_o        (fwd_a),
        .fwd_b_o        (fwd_b),
        .fwd_d_o        (fwd_d)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idex_q <= '0;
        end else if (flush_idex) begin
            idex_q <= '0;
        end else begin
            idex_q.valid    <= valid_id;
            idex_q.ctrl     <= ctrl_id;
            idex_q.pc_plus8 <= pc_plus8_id;
            idex_q.rn_addr  <= rn_id;
            idex_q.rm_addr  <= rm_id;
            idex_q.rd_addr  <= rd_id;
            idex_q.rn_data  <= rn_data_id;
            idex_q.rm_data  <= rm_data_id;
            idex_q.rd_data  <= rd_data_id;
            idex_q.imm32    <= imm32_id;
        end
    end

    execute_stage execute_stage_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .idex_i          (idex_q),
        .fwd_a_i         (fwd_a),
        .fwd_b_i         (fwd_b),
        .fwd_d_i         (fwd_d),
        .exmem_fwd_i     (exmem_fwd),
        .memwb_fwd_i     (wb_data),
        .exmem_o         (exmem_d),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exmem_q <= '0;
        end else begin
            exmem_q <= exmem_d;
        end
    end

    // BL result in EX/MEM is the link address, not the ALU output
    assign exmem_fwd = (exmem_q.wb_sel == arm_pkg::WB_LINK) ? exmem_q.pc_plus4
                                                             : exmem_q.alu_result;

    assign d_mem_addr_o = exmem_q.mem_addr;
    assign d_mem_data_o = exmem_q.store_data;
    assign d_mem_wen_o  = exmem_q.mem_write;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            memwb_q <= '0;
        end else begin
            memwb_q.wr_en      <= exmem_q.wr_en;
            memwb_q.wr_addr    <= exmem_q.wr_addr;
            memwb_q.wb_sel     <= exmem_q.wb_sel;
            memwb_q.alu_result <= exmem_q.alu_result;
            memwb_q.pc_plus4   <= exmem_q.pc_plus4;
        end
    end

    // Load data arrives from the memory during WB
    always_comb begin
        case (memwb_q.wb_sel)
            arm_pkg::WB_MEM:  wb_data = d_mem_data_i;
            arm_pkg::WB_LINK: wb_data = memwb_q.pc_plus4;
            default:          wb_data = memwb_q.alu_result;
        endcase
    end

endmodule

`default_nettype wire

// File: sim/tb_arm_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_arm_core;

    localparam int GOLD_WORDS = 95;   // Header, program and store pairs
    localparam int DMEM_WORDS = 256;

    logic        clk;
    logic        rst_n = 1'b0;
    logic [31:0] i_mem_data = '0;
    logic [31:0] i_mem_addr;
    logic [31:0] d_mem_rdata = '0;
    logic [31:0] d_mem_addr;
    logic [31:0] d_mem_wdata;
    logic        d_mem_wen;
    logic        done;

    logic [31:0] golden [GOLD_WORDS];
    logic [31:0] dmem [DMEM_WORDS];

    int prog_words;
    int exp_writes;
    int write_count;
    int value_errors;
    int count_errors;
    int timeouts;
    int cycle;
    int cycle_limit;

    arm_core arm_core_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_mem_data_i (i_mem_data),
        .i_mem_addr_o (i_mem_addr),
        .d_mem_data_i (d_mem_rdata),
        .d_mem_addr_o (d_mem_addr),
        .d_mem_data_o (d_mem_wdata),
        .d_mem_wen_o  (d_mem_wen),
        .done_o       (done)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // Words past the program read as zero
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [29:0] idx;
        idx = addr[31:2];
        if (idx < 30'(prog_words)) begin
            return golden[2 + int'(idx)];
        end
        return 32'd0;
    endfunction

    // Both memories answer one cycle after the address
    always @(posedge clk) begin
        i_mem_data  <= fetch_word(i_mem_addr);
        d_mem_rdata <= dmem[d_mem_addr[9:2]];
        if (!rst_n) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (d_mem_wen) begin
            dmem[d_mem_addr[9:2]] <= d_mem_wdata;
        end
    end

    task automatic check_store();
        int base;
        base = 2 + prog_words + 2 * write_count;
        assert (write_count < exp_writes && base + 1 < GOLD_WORDS) else begin
            $display("Unexpected extra store to address 0x%h", d_mem_addr);
            count_errors++;
        end
        if (write_count < exp_writes && base + 1 < GOLD_WORDS) begin
            assert (d_mem_addr == golden[base]) else begin
                $display("** Error: d_mem_addr_o = 0x%h, expected 0x%h (store %0d)",
                         d_mem_addr, golden[base], write_count);
                value_errors++;
            end
            assert (d_mem_wdata == golden[base + 1]) else begin
                $display("** Error: d_mem_data_o = 0x%h, expected 0x%h (store %0d)",
                         d_mem_wdata, golden[base + 1], write_count);
                value_errors++;
            end
        end
        write_count++;
    endtask

    initial begin
        write_count  = 0;
        value_errors = 0;
        count_errors = 0;
        timeouts     = 0;
        cycle        = 0;
        $readmemh("sim/golden_program.txt", golden);
        prog_words  = int'(golden[0]);
        exp_writes  = int'(golden[1]);
        cycle_limit = 10 * prog_words + 100;
        assert (2 + prog_words + 2 * exp_writes == GOLD_WORDS) else begin
            $display("Golden file header does not match the number of words in it");
            count_errors++;
        end

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // Outputs are sampled on the falling edge
        while (!done && cycle < cycle_limit) begin
            @(negedge clk);
            cycle++;
            if (d_mem_wen) begin
                check_store();
            end
        end

        if (!done) begin
            $display("Timeout: done was never reached within %0d cycles", cycle_limit);
            timeouts++;
        end else begin
            // Stores behind the final branch would reach MEM in these cycles
            repeat (3) begin
                @(negedge clk);
                if (d_mem_wen) begin
                    check_store();
                end
            end
        end
        assert (write_count >= exp_writes) else begin
            $display("Too few stores: saw %0d, expected %0d", write_count, exp_writes);
            count_errors++;
        end

        $display("Value errors: %0d, store count errors: %0d, timeouts: %0d",
                 value_errors, count_errors, timeouts);
        if (value_errors + count_errors + timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/golden_program.txt
// First line: program word count, expected store count
// Then program words from address 0, then store address and data pairs in order
00000037 00000013
// Forwarding through ALU results
E3A01005 E2812003 E5802000 E0823001 E0434001
E2645014 E5803004 E5805008 E0256004 E38674FF
E0078003 E3E09000 E580700C E5808010 E5809014
// Load-use stalls, negative offset and post-index
E590A004 E28AB001 E580B018 E590C014 E580C01C
E3A01024 E501B004 E4815008 E3A02000 E3510024
// Conditional MOVs after CMP
03A02001 13A02002 E5802028 E3540009 B3A03007
A3A03009 33A06033 23A06044 E580302C E5806030
A5803034 E3510010 A3A03055 83A06066 E5803034
// Branches, BL, PC reads, jump to the end address
E5806038 EA000001 E5801040 E5801044 0A000001
E580903C EB000001 E5801048 E580104C E580E040
E28F1000 E5801044 E580F048 EAFFFFC8 E5801050
// Expected stores
00000000 00000008 00000004 0000000D
00000008 0000000C 0000000C FF000004
00000010 00000004 00000014 FFFFFFFF
00000018 0000000E 0000001C FFFFFFFF
00000020 0000000E 00000024 0000000C
00000028 00000001 0000002C 00000007
00000030 00000033 00000034 00000055
00000038 00000066 0000003C FFFFFFFF
00000040 000000BC 00000044 000000D0
00000048 000000D8

// File: filelist.f
hdl/arm_pkg.sv
hdl/fetch_stage.sv
hdl/decoder.sv
hdl/regfile.sv
hdl/hazard_unit.sv
hdl/execute_stage.sv
hdl/arm_core.sv
sim/tb_arm_core.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_arm_core -f filelist.f -Mdir obj_dir -o tb_arm_core

./obj_dir/tb_arm_core | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1
